/* src.f */
verilog/xfer_ctrl_pkg.sv
verilog/pulse_sync.sv
verilog/seq_ram_reader.sv
verilog/csr_instrn_handler.sv
verilog/main_cntrl_engine.sv
verilog/main_controller_wrapper.sv
tb/seq_ram_model.sv
tb/tb_main_controller.sv

/* Bender.yml */
package:
  name: main_controller

sources:
  - verilog/xfer_ctrl_pkg.sv
  - verilog/pulse_sync.sv
  - verilog/seq_ram_reader.sv
  - verilog/csr_instrn_handler.sv
  - verilog/main_cntrl_engine.sv
  - verilog/main_controller_wrapper.sv
  - target: test
    files:
      - tb/seq_ram_model.sv
      - tb/tb_main_controller.sv

/* tb/tb_main_controller.sv */
module tb_main_controller;

  timeunit 1ns;
  timeprecision 1ps;

  import xfer_ctrl_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int TEST_NS   = 2000;
  localparam int WAIT_MAX  = 200;
  localparam int DONE_DLY  = 3;
  localparam int RAND_CMDS = 12;

  logic                  axi_clk;
  logic                  mem_clk;
  logic                  rst_n;
  logic                  slv_cmd_valid;
  axi_cmd_t              slv_cmd;
  logic                  slv_cmd_ready;
  logic                  spl_instrn_req;
  logic                  spl_instrn_ack;
  logic                  spl_instrn_stall;
  logic                  csr_cmd_xfer_valid;
  csr_cmd_t              csr_cmd;
  logic                  csr_cmd_xfer_ack;
  logic                  csr_cmd_xfer_success;
  logic                  def_seq_sel;
  logic [SEQ_ID_W-1:0]   rd_seq_id;
  logic [SEQ_ID_W-1:0]   wr_seq_id;
  seq_bundle_t           def_rd_seq;
  seq_bundle_t           def_wr_seq;
  logic [SEQ_RAM_AW-1:0] seq_ram_rd_addr;
  logic                  seq_ram_rd_en;
  logic [31:0]           seq_ram_rd_data;
  logic                  xfer_req_valid;
  xfer_req_t             xfer_req;
  logic                  xfer_req_ready;
  logic                  xfer_done;
  logic                  xfer_err;

  int          errors;
  int          tests_failed;
  int          test_base;
  int          done_cnt;
  logic [31:0] lfsr;
  logic [31:0] rdy_lfsr;
  logic        rand_ready;
  logic        err_mode;
  logic        rd_en_seen;
  logic        outstanding;
  logic        hold_prev;
  xfer_req_t   req_prev;
  xfer_req_t   req_q[$];

  main_controller_wrapper u_main_controller_wrapper (
    .axi_clk              (axi_clk),
    .mem_clk              (mem_clk),
    .rst_n                (rst_n),
    .slv_cmd_valid        (slv_cmd_valid),
    .slv_cmd              (slv_cmd),
    .slv_cmd_ready        (slv_cmd_ready),
    .spl_instrn_req       (spl_instrn_req),
    .spl_instrn_ack       (spl_instrn_ack),
    .spl_instrn_stall     (spl_instrn_stall),
    .csr_cmd_xfer_valid   (csr_cmd_xfer_valid),
    .csr_cmd              (csr_cmd),
    .csr_cmd_xfer_ack     (csr_cmd_xfer_ack),
    .csr_cmd_xfer_success (csr_cmd_xfer_success),
    .def_seq_sel          (def_seq_sel),
    .rd_seq_id            (rd_seq_id),
    .wr_seq_id            (wr_seq_id),
    .def_rd_seq           (def_rd_seq),
    .def_wr_seq           (def_wr_seq),
    .seq_ram_rd_addr      (seq_ram_rd_addr),
    .seq_ram_rd_en        (seq_ram_rd_en),
    .seq_ram_rd_data      (seq_ram_rd_data),
    .xfer_req_valid       (xfer_req_valid),
    .xfer_req             (xfer_req),
    .xfer_req_ready       (xfer_req_ready),
    .xfer_done            (xfer_done),
    .xfer_err             (xfer_err)
  );

  seq_ram_model u_seq_ram_model (
    .mem_clk (mem_clk),
    .rd_en   (seq_ram_rd_en),
    .rd_addr (seq_ram_rd_addr),
    .rd_data (seq_ram_rd_data)
  );

  always #4 axi_clk = ~axi_clk;

  // mem_clk trails axi_clk by 3 ns
  always @(axi_clk) begin
    mem_clk <= #3 axi_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic axi_cmd_t rand_cmd(input logic wr);
    axi_cmd_t    c;
    logic [63:0] v;
    v = rand_bits(46);
    c.addr    = v[45:14];
    c.write   = wr;
    c.axi_len = v[13:6];
    c.burst   = v[5:4];
    c.size    = v[3:1];
    c.err     = v[0];
    return c;
  endfunction

  function automatic seq_bundle_t rand_seq();
    seq_bundle_t s;
    logic [63:0] v;
    for (int i = 0; i < SEQ_DWORDS; i++) begin
      v = rand_bits(32);
      s[i] = v[31:0];
    end
    return s;
  endfunction

  // Sequence id k occupies dwords 4k to 4k+3
  function automatic seq_bundle_t ram_seq(input logic [SEQ_ID_W-1:0] id);
    seq_bundle_t s;
    logic [31:0] base;
    base = {24'h0, id} * 32'd4;
    for (int i = 0; i < SEQ_DWORDS; i++) begin
      s[i] = (base + i) ^ 32'h5a5a0000;
    end
    return s;
  endfunction

  task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_fail(input string what);
    $display("Failure at %0d ns: %s", $time, what);
    errors++;
  endtask

  task automatic begin_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_base) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - test_base);
      tests_failed++;
    end
  endtask

  // Memory side and bus monitor
  always @(posedge mem_clk) begin
    if (rand_ready) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      xfer_req_ready <= rdy_lfsr[0];
    end else begin
      xfer_req_ready <= 1'b1;
    end
    xfer_done <= 1'b0;
    if (done_cnt > 0) begin
      done_cnt = done_cnt - 1;
      if (done_cnt == 0) begin
        xfer_done <= 1'b1;
        xfer_err  <= err_mode;
      end
    end else if (xfer_req_valid && xfer_req_ready) begin
      done_cnt = DONE_DLY;
      req_q.push_back(xfer_req);
    end
    if (seq_ram_rd_en) begin
      rd_en_seen = 1'b1;
    end
    if (outstanding) begin
      check("slv_cmd_ready", slv_cmd_ready, 1'b0);
    end
    if (hold_prev) begin
      check("xfer_req_valid", xfer_req_valid, 1'b1);
      check("xfer_req", xfer_req, req_prev);
    end
    hold_prev = xfer_req_valid && !xfer_req_ready;
    req_prev  = xfer_req;
    if (slv_cmd_valid && slv_cmd_ready) begin
      outstanding = 1'b1;
    end
    if (xfer_done) begin
      outstanding = 1'b0;
    end
  end

  // Callers sit on a mem_clk edge
  task automatic send_axi(input axi_cmd_t c);
    int n;
    slv_cmd_valid <= 1'b1;
    slv_cmd       <= c;
    n = 0;
    do begin
      @(posedge mem_clk);
      n++;
    end while (!slv_cmd_ready && n < WAIT_MAX);
    slv_cmd_valid <= 1'b0;
    if (!slv_cmd_ready) begin
      report_fail("AXI command was never accepted");
    end
  endtask

  task automatic wait_req(output xfer_req_t r);
    int n;
    n = 0;
    while (req_q.size() == 0 && n < WAIT_MAX) begin
      @(posedge mem_clk);
      n++;
    end
    if (req_q.size() == 0) begin
      report_fail("no transfer request reached the memory side");
      r = '0;
    end else begin
      r = req_q.pop_front();
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge mem_clk);
      n++;
    end while (!slv_cmd_ready && n < WAIT_MAX);
    if (!slv_cmd_ready) begin
      report_fail("engine did not return to idle");
    end
  endtask

  task automatic run_axi(input axi_cmd_t c, input seq_bundle_t exp_seq);
    xfer_req_t exp;
    xfer_req_t r;
    exp     = '0;
    exp.cmd = c;
    exp.seq = exp_seq;
    send_axi(c);
    wait_req(r);
    check("xfer_req", r, exp);
    wait_idle();
  endtask

  task automatic run_csr(input logic err);
    csr_cmd_t    cc;
    xfer_req_t   exp;
    xfer_req_t   r;
    logic [63:0] v;
    int          n;
    v = rand_bits(25);
    cc.opcode              = v[24:9];
    cc.no_of_pins          = v[8:7];
    cc.data_rate           = v[6];
    cc.wr_data_en          = !err;
    cc.no_of_wr_data_bytes = v[5:0];
    cc.wr_data             = rand_bits(64);
    err_mode = err;
    @(posedge axi_clk);
    csr_cmd            <= cc;
    csr_cmd_xfer_valid <= 1'b1;
    @(posedge axi_clk);
    csr_cmd_xfer_valid <= 1'b0;
    n = 0;
    while (!spl_instrn_req && n < WAIT_MAX) begin
      @(posedge axi_clk);
      n++;
    end
    if (!spl_instrn_req) begin
      report_fail("spl_instrn_req never rose");
    end
    spl_instrn_ack <= 1'b1;
    @(posedge axi_clk);
    spl_instrn_ack <= 1'b0;
    @(posedge axi_clk);
    check("spl_instrn_stall", spl_instrn_stall, 1'b1);
    check("spl_instrn_req", spl_instrn_req, 1'b0);
    exp        = '0;
    exp.is_csr = 1'b1;
    exp.csr    = cc;
    wait_req(r);
    check("xfer_req", r, exp);
    n = 0;
    while (!csr_cmd_xfer_ack && n < WAIT_MAX) begin
      @(posedge axi_clk);
      n++;
    end
    if (!csr_cmd_xfer_ack) begin
      report_fail("csr_cmd_xfer_ack never pulsed");
    end
    check("csr_cmd_xfer_success", csr_cmd_xfer_success, !err);
    check("spl_instrn_stall", spl_instrn_stall, 1'b0);
    @(posedge axi_clk);
    check("csr_cmd_xfer_ack", csr_cmd_xfer_ack, 1'b0);
    check("csr_cmd_xfer_success", csr_cmd_xfer_success, 1'b0);
    wait_idle();
  endtask

  task automatic test_axi_read();
    begin_test();
    @(posedge mem_clk);
    def_seq_sel <= 1'b0;
    rd_seq_id   <= 8'h2c;
    wr_seq_id   <= 8'h91;
    run_axi(rand_cmd(1'b0), ram_seq(8'h2c));
    end_test("AXI read from sequence RAM");
  endtask

  task automatic test_axi_write();
    begin_test();
    @(posedge mem_clk);
    def_seq_sel <= 1'b0;
    rd_seq_id   <= 8'h07;
    wr_seq_id   <= 8'hff;
    run_axi(rand_cmd(1'b1), ram_seq(8'hff));
    end_test("AXI write from sequence RAM");
  endtask

  task automatic test_default_seq();
    seq_bundle_t rd_s;
    seq_bundle_t wr_s;
    begin_test();
    rd_s = rand_seq();
    wr_s = rand_seq();
    @(posedge mem_clk);
    def_seq_sel <= 1'b1;
    def_rd_seq  <= rd_s;
    def_wr_seq  <= wr_s;
    rd_en_seen = 1'b0;
    run_axi(rand_cmd(1'b0), rd_s);
    run_axi(rand_cmd(1'b1), wr_s);
    check("seq_ram_rd_en seen", rd_en_seen, 1'b0);
    def_seq_sel <= 1'b0;
    end_test("default sequences");
  endtask

  task automatic test_csr_ok();
    begin_test();
    run_csr(1'b0);
    end_test("CSR command success");
  endtask

  task automatic test_csr_err();
    begin_test();
    run_csr(1'b1);
    end_test("CSR command error");
  endtask

  task automatic test_random_backpressure();
    axi_cmd_t    c;
    logic [63:0] v;
    begin_test();
    rand_ready <= 1'b1;
    for (int i = 0; i < RAND_CMDS; i++) begin
      v = rand_bits(17);
      c = rand_cmd(v[16]);
      rd_seq_id <= v[15:8];
      wr_seq_id <= v[7:0];
      run_axi(c, ram_seq(c.write ? v[7:0] : v[15:8]));
    end
    rand_ready <= 1'b0;
    end_test("random AXI with back-pressure");
  endtask

  initial begin
    axi_clk            = 1'b0;
    mem_clk            = 1'b0;
    rst_n              = 1'b0;
    slv_cmd_valid      = 1'b0;
    slv_cmd            = '0;
    spl_instrn_ack     = 1'b0;
    csr_cmd_xfer_valid = 1'b0;
    csr_cmd            = '0;
    def_seq_sel        = 1'b0;
    rd_seq_id          = '0;
    wr_seq_id          = '0;
    def_rd_seq         = '0;
    def_wr_seq         = '0;
    xfer_req_ready     = 1'b0;
    xfer_done          = 1'b0;
    xfer_err           = 1'b0;
    errors             = 0;
    tests_failed       = 0;
    done_cnt           = 0;
    lfsr               = 32'hf37;
    rdy_lfsr           = 32'hf37;
    rand_ready         = 1'b0;
    err_mode           = 1'b0;
    rd_en_seen         = 1'b0;
    outstanding        = 1'b0;
    hold_prev          = 1'b0;
    repeat (8) @(posedge axi_clk);
    check("outputs in reset", {slv_cmd_ready, xfer_req_valid, seq_ram_rd_en, spl_instrn_req,
                               spl_instrn_stall, csr_cmd_xfer_ack, csr_cmd_xfer_success}, 7'b0);
    repeat (8) @(posedge axi_clk);
    rst_n <= 1'b1;
    wait_idle();
    test_axi_read();
    test_axi_write();
    test_default_seq();
    test_csr_ok();
    test_csr_err();
    test_random_backpressure();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * TEST_NS);
    $display("Simulation timed out after %0d ns", NUM_TESTS * TEST_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* tb/seq_ram_model.sv */
module seq_ram_model (
  input  logic                                 mem_clk,
  input  logic                                 rd_en,
  input  logic [xfer_ctrl_pkg::SEQ_RAM_AW-1:0] rd_addr,
  output logic [31:0]                          rd_data
);

  timeunit 1ns;
  timeprecision 1ps;

  import xfer_ctrl_pkg::*;

  // Contents follow from the address, nothing to load
  function automatic logic [31:0] word_at(input logic [SEQ_RAM_AW-1:0] a);
    logic [31:0] full;
    full = {{(32 - SEQ_RAM_AW){1'b0}}, a};
    return full ^ 32'h5a5a0000;
  endfunction

  initial begin
    rd_data = '0;
  end

  // One cycle read latency.
  // Data outside a read is poisoned so a stray capture shows up
  always @(posedge mem_clk) begin
    if (rd_en) begin
      rd_data <= word_at(rd_addr);
    end else begin
      rd_data <= 'x;
    end
  end

endmodule

/* verilog/main_controller_wrapper.sv */
module main_controller_wrapper (
  input  logic                                axi_clk,
  input  logic                                mem_clk,
  input  logic                                rst_n,
  input  logic                                slv_cmd_valid,
  input  xfer_ctrl_pkg::axi_cmd_t             slv_cmd,
  output logic                                slv_cmd_ready,
  output logic                                spl_instrn_req,
  input  logic                                spl_instrn_ack,
  output logic                                spl_instrn_stall,
  input  logic                                csr_cmd_xfer_valid,
  input  xfer_ctrl_pkg::csr_cmd_t             csr_cmd,
  output logic                                csr_cmd_xfer_ack,
  output logic                                csr_cmd_xfer_success,
  input  logic                                def_seq_sel,
  input  logic [xfer_ctrl_pkg::SEQ_ID_W-1:0]  rd_seq_id,
  input  logic [xfer_ctrl_pkg::SEQ_ID_W-1:0]  wr_seq_id,
  input  xfer_ctrl_pkg::seq_bundle_t          def_rd_seq,
  input  xfer_ctrl_pkg::seq_bundle_t          def_wr_seq,
  output logic [xfer_ctrl_pkg::SEQ_RAM_AW-1:0] seq_ram_rd_addr,
  output logic                                seq_ram_rd_en,
  input  logic [31:0]                         seq_ram_rd_data,
  output logic                                xfer_req_valid,
  output xfer_ctrl_pkg::xfer_req_t            xfer_req,
  input  logic                                xfer_req_ready,
  input  logic                                xfer_done,
  input  logic                                xfer_err
);

  import xfer_ctrl_pkg::*;

  logic        fetch_valid;
  logic        fetch_write;
  logic        fetch_ready;
  logic        seq_valid;
  seq_bundle_t seq;
  logic        csr_go;
  logic        csr_done;
  logic        csr_ok;

  seq_ram_reader u_seq_ram_reader (
    .mem_clk         (mem_clk),
    .rst_n           (rst_n),
    .fetch_valid     (fetch_valid),
    .fetch_write     (fetch_write),
    .fetch_ready     (fetch_ready),
    .def_seq_sel     (def_seq_sel),
    .rd_seq_id       (rd_seq_id),
    .wr_seq_id       (wr_seq_id),
    .def_rd_seq      (def_rd_seq),
    .def_wr_seq      (def_wr_seq),
    .seq_ram_rd_addr (seq_ram_rd_addr),
    .seq_ram_rd_en   (seq_ram_rd_en),
    .seq_ram_rd_data (seq_ram_rd_data),
    .seq_valid       (seq_valid),
    .seq             (seq)
  );

  // axi_clk side of CSR commands
  csr_instrn_handler u_csr_instrn_handler (
    .axi_clk              (axi_clk),
    .mem_clk              (mem_clk),
    .rst_n                (rst_n),
    .csr_cmd_xfer_valid   (csr_cmd_xfer_valid),
    .spl_instrn_req       (spl_instrn_req),
    .spl_instrn_ack       (spl_instrn_ack),
    .spl_instrn_stall     (spl_instrn_stall),
    .csr_go               (csr_go),
    .csr_done             (csr_done),
    .csr_ok               (csr_ok),
    .csr_cmd_xfer_ack     (csr_cmd_xfer_ack),
    .csr_cmd_xfer_success (csr_cmd_xfer_success)
  );

  main_cntrl_engine u_main_cntrl_engine (
    .mem_clk          (mem_clk),
    .rst_n            (rst_n),
    .slv_cmd_valid    (slv_cmd_valid),
    .slv_cmd          (slv_cmd),
    .slv_cmd_ready    (slv_cmd_ready),
    .csr_go           (csr_go),
    .spl_instrn_stall (spl_instrn_stall),
    .csr_cmd          (csr_cmd),
    .fetch_valid      (fetch_valid),
    .fetch_write      (fetch_write),
    .fetch_ready      (fetch_ready),
    .seq_valid        (seq_valid),
    .seq              (seq),
    .xfer_req_valid   (xfer_req_valid),
    .xfer_req         (xfer_req),
    .xfer_req_ready   (xfer_req_ready),
    .xfer_done        (xfer_done),
    .xfer_err         (xfer_err),
    .csr_done         (csr_done),
    .csr_ok           (csr_ok)
  );

endmodule

/* verilog/main_cntrl_engine.sv */
module main_cntrl_engine (
  input  logic                       mem_clk,
  input  logic                       rst_n,
  input  logic                       slv_cmd_valid,
  input  xfer_ctrl_pkg::axi_cmd_t    slv_cmd,
  output logic                       slv_cmd_ready,
  input  logic                       csr_go,
  input  logic                       spl_instrn_stall,
  input  xfer_ctrl_pkg::csr_cmd_t    csr_cmd,
  output logic                       fetch_valid,
  output logic                       fetch_write,
  input  logic                       fetch_ready,
  input  logic                       seq_valid,
  input  xfer_ctrl_pkg::seq_bundle_t seq,
  output logic                       xfer_req_valid,
  output xfer_ctrl_pkg::xfer_req_t   xfer_req,
  input  logic                       xfer_req_ready,
  input  logic                       xfer_done,
  input  logic                       xfer_err,
  output logic                       csr_done,
  output logic                       csr_ok
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_WAIT_SEQ,
    S_ISSUE,
    S_WAIT_DONE
  } state_t;

  state_t state;
  logic   stall_meta;
  logic   stall_sync;
  logic   csr_pend;
  logic   csr_start;
  logic   axi_start;

  // CSR wins over AXI whenever the engine is idle
  assign csr_start     = (state == S_IDLE) && (csr_go || csr_pend);
  assign slv_cmd_ready = (state == S_IDLE) && !stall_sync && !csr_pend && !csr_go;
  assign axi_start     = slv_cmd_valid && slv_cmd_ready;

  assign fetch_valid    = (state == S_FETCH);
  assign fetch_write    = xfer_req.cmd.write;
  assign xfer_req_valid = (state == S_ISSUE);

  // Stall comes from axi_clk.
  // Flops come up high, so ready stays low until they have settled
  always_ff @(posedge mem_clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_meta <= 1'b1;
      stall_sync <= 1'b1;
    end else begin
      stall_meta <= spl_instrn_stall;
      stall_sync <= stall_meta;
    end
  end

  always_ff @(posedge mem_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      csr_pend <= 1'b0;
      csr_done <= 1'b0;
      csr_ok   <= 1'b0;
    end else begin
      csr_done <= 1'b0;
      csr_ok   <= 1'b0;
      // Hold a go that shows up mid-transfer
      if (csr_start) begin
        csr_pend <= 1'b0;
      end else if (csr_go) begin
        csr_pend <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (csr_start) begin
            state <= S_ISSUE;
          end else if (axi_start) begin
            state <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (fetch_ready) begin
            state <= S_WAIT_SEQ;
          end
        end
        S_WAIT_SEQ: begin
          if (seq_valid) begin
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          if (xfer_req_ready) begin
            state <= S_WAIT_DONE;
          end
        end
        S_WAIT_DONE: begin
          if (xfer_done) begin
            state    <= S_IDLE;
            csr_done <= xfer_req.is_csr;
            csr_ok   <= xfer_req.is_csr && !xfer_err;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge mem_clk) begin
    if (csr_start) begin
      xfer_req.is_csr <= 1'b1;
      xfer_req.cmd    <= '0;
      xfer_req.csr    <= csr_cmd;
      xfer_req.seq    <= '0;
    end else if (axi_start) begin
      xfer_req.is_csr <= 1'b0;
      xfer_req.cmd    <= slv_cmd;
      xfer_req.csr    <= '0;
    end
    if ((state == S_WAIT_SEQ) && seq_valid) begin
      xfer_req.seq <= seq;
    end
  end

  a_req_stable: assert property (@(posedge mem_clk) disable iff (!rst_n)
    xfer_req_valid && !xfer_req_ready |=> xfer_req_valid && $stable(xfer_req));

endmodule

/* verilog/csr_instrn_handler.sv */
module csr_instrn_handler (
  input  logic axi_clk,
  input  logic mem_clk,
  input  logic rst_n,
  input  logic csr_cmd_xfer_valid,
  output logic spl_instrn_req,
  input  logic spl_instrn_ack,
  output logic spl_instrn_stall,
  output logic csr_go,
  input  logic csr_done,
  input  logic csr_ok,
  output logic csr_cmd_xfer_ack,
  output logic csr_cmd_xfer_success
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_STALL,
    S_DONE
  } state_t;

  state_t state;
  logic   go_src;
  logic   done_sync;
  logic   ok_sync;
  logic   ok_q;

  assign spl_instrn_req       = (state == S_REQ);
  assign spl_instrn_stall     = (state == S_STALL);
  assign csr_cmd_xfer_ack     = (state == S_DONE);
  assign csr_cmd_xfer_success = ok_q;

  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      go_src <= 1'b0;
      ok_q   <= 1'b0;
    end else begin
      // Go is launched together with the stall
      go_src <= (state == S_REQ) && spl_instrn_ack;
      ok_q   <= (state == S_STALL) && done_sync && ok_sync;
      case (state)
        S_IDLE: begin
          if (csr_cmd_xfer_valid) begin
            state <= S_REQ;
          end
        end
        S_REQ: begin
          if (spl_instrn_ack) begin
            state <= S_STALL;
          end
        end
        S_STALL: begin
          if (done_sync) begin
            state <= S_DONE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  pulse_sync u_go_sync (
    .src_clk   (axi_clk),
    .dst_clk   (mem_clk),
    .rst_n     (rst_n),
    .in_pulse  (go_src),
    .out_pulse (csr_go)
  );

  // Done and ok leave the engine on the same edge
  pulse_sync u_done_sync (
    .src_clk   (mem_clk),
    .dst_clk   (axi_clk),
    .rst_n     (rst_n),
    .in_pulse  (csr_done),
    .out_pulse (done_sync)
  );

  pulse_sync u_ok_sync (
    .src_clk   (mem_clk),
    .dst_clk   (axi_clk),
    .rst_n     (rst_n),
    .in_pulse  (csr_ok),
    .out_pulse (ok_sync)
  );

  // No new request to the slave until this command is acked
  a_no_req_in_stall: assert property (@(posedge axi_clk) disable iff (!rst_n)
    $rose(spl_instrn_stall) |-> !spl_instrn_req throughout csr_cmd_xfer_ack [->1]);

endmodule

/* verilog/seq_ram_reader.sv */
module seq_ram_reader (
  input  logic                                mem_clk,
  input  logic                                rst_n,
  input  logic                                fetch_valid,
  input  logic                                fetch_write,
  output logic                                fetch_ready,
  input  logic                                def_seq_sel,
  input  logic [xfer_ctrl_pkg::SEQ_ID_W-1:0]  rd_seq_id,
  input  logic [xfer_ctrl_pkg::SEQ_ID_W-1:0]  wr_seq_id,
  input  xfer_ctrl_pkg::seq_bundle_t          def_rd_seq,
  input  xfer_ctrl_pkg::seq_bundle_t          def_wr_seq,
  output logic [xfer_ctrl_pkg::SEQ_RAM_AW-1:0] seq_ram_rd_addr,
  output logic                                seq_ram_rd_en,
  input  logic [31:0]                         seq_ram_rd_data,
  output logic                                seq_valid,
  output xfer_ctrl_pkg::seq_bundle_t          seq
);

  import xfer_ctrl_pkg::*;

  logic                          busy;
  logic                          def_pend;
  logic                          def_write;
  logic                          start;
  logic                          rd_vld_d;
  logic                          last_rd;
  logic [$clog2(SEQ_DWORDS)-1:0] cnt;
  logic [$clog2(SEQ_DWORDS)-1:0] rd_idx_d;
  logic [SEQ_ID_W-1:0]           id_q;

  assign fetch_ready = !busy;
  assign start       = fetch_valid && !busy;

  // Dword address is the id with the counter appended
  assign seq_ram_rd_addr = {id_q, cnt};

  // RAM data lands one cycle after each read
  assign last_rd = rd_vld_d && (rd_idx_d == SEQ_DWORDS - 1);

  always_ff @(posedge mem_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= 1'b0;
      def_pend      <= 1'b0;
      seq_ram_rd_en <= 1'b0;
      cnt           <= '0;
      rd_vld_d      <= 1'b0;
      rd_idx_d      <= '0;
      seq_valid     <= 1'b0;
    end else begin
      seq_valid <= 1'b0;
      rd_vld_d  <= seq_ram_rd_en;
      rd_idx_d  <= cnt;
      if (start) begin
        busy          <= 1'b1;
        cnt           <= '0;
        def_pend      <= def_seq_sel;
        seq_ram_rd_en <= !def_seq_sel;
      end else if (seq_ram_rd_en) begin
        cnt <= cnt + 1'b1;
        if (cnt == SEQ_DWORDS - 1) begin
          seq_ram_rd_en <= 1'b0;
        end
      end
      // Strap path answers after a single cycle
      if (def_pend || last_rd) begin
        def_pend  <= 1'b0;
        busy      <= 1'b0;
        seq_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge mem_clk) begin
    if (start) begin
      id_q      <= fetch_write ? wr_seq_id : rd_seq_id;
      def_write <= fetch_write;
    end
    if (def_pend) begin
      seq <= def_write ? def_wr_seq : def_rd_seq;
    end
    if (rd_vld_d) begin
      seq[rd_idx_d] <= seq_ram_rd_data;
    end
  end

  a_no_rd_when_idle: assert property (@(posedge mem_clk) disable iff (!rst_n)
    !busy |-> !seq_ram_rd_en);

endmodule

/* verilog/pulse_sync.sv */
module pulse_sync (
  input  logic src_clk,
  input  logic dst_clk,
  input  logic rst_n,
  input  logic in_pulse,
  output logic out_pulse
);

  logic       src_tgl;
  logic [2:0] dst_sync;

  // Each source pulse flips the level
  always_ff @(posedge src_clk or negedge rst_n) begin
    if (!rst_n) begin
      src_tgl <= 1'b0;
    end else if (in_pulse) begin
      src_tgl <= ~src_tgl;
    end
  end

  // Two flops for metastability, third one for the edge detect
  always_ff @(posedge dst_clk or negedge rst_n) begin
    if (!rst_n) begin
      dst_sync <= '0;
    end else begin
      dst_sync <= {dst_sync[1:0], src_tgl};
    end
  end

  assign out_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

/* verilog/xfer_ctrl_pkg.sv */
package xfer_ctrl_pkg;

  // AXI command address width
  localparam int ADDR_W = 32;

  // Sequence RAM is addressed in dwords
  localparam int SEQ_RAM_AW = 10;

  // One instruction sequence is four dwords
  localparam int SEQ_DWORDS = 4;

  // Sequence id k starts at dword 4k
  localparam int SEQ_ID_W = 8;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [7:0]        axi_len;
    logic [1:0]        burst;
    logic [2:0]        size;
    logic              err;
  } axi_cmd_t;

  // Command transfer programmed through the CSR block
  typedef struct packed {
    logic [15:0] opcode;
    logic [1:0]  no_of_pins;
    logic        data_rate;
    logic        wr_data_en;
    logic [5:0]  no_of_wr_data_bytes;
    logic [63:0] wr_data;
  } csr_cmd_t;

  // Dword 0 sits in the low bits
  typedef logic [SEQ_DWORDS-1:0][31:0] seq_bundle_t;

  // Request toward the memory transfer interface
  typedef struct packed {
    logic        is_csr;
    axi_cmd_t    cmd;
    csr_cmd_t    csr;
    seq_bundle_t seq;
  } xfer_req_t;

endpackage
